// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module cartridge_tb -Mdir obj_dir
	./obj_dir/Vcartridge_tb | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+logic
logic/cart_pkg.sv
logic/rom_loader.sv
logic/header_detect.sv
logic/md_bank_regs.sv
logic/md_mapper.sv
logic/cartridge_top.sv
testbench/cartridge_tb.sv

// File: logic/cart_defs.svh
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// ==========================================================================
// Cartridge header layout (download byte addresses)
// ==========================================================================

// First of the six ID words, 11 characters in all
`define CART_ID_ADDR          25'h180
// Write here closes the header and runs the ID tables
`define CART_ID_DONE_ADDR     25'h190
// Initial stack pointer, first word of every image
`define CART_SP_ADDR          25'h000

// ==========================================================================
// Mapper and SRAM sizing
// ==========================================================================

// Any mask bit in this field means an image above 4 MB
`define CART_BANK_MASK_TOP    24
`define CART_BANK_MASK_BOT    22

// 32 KB battery SRAM
`define CART_SRAM_AW          15

// Light gun sensor delay when the ID is not in the table
`define CART_GUN_DELAY_DEFAULT 8'd44

`endif

// File: logic/cart_pkg.sv
`default_nettype none

package cart_pkg;

	// ROM word address, byte address bits 24:1
	typedef logic [24:1] word_addr_t;

	// 68000 bus word address
	typedef logic [23:1] bus_addr_t;

	// Data word on the cartridge bus and the download port
	typedef logic [15:0] bus_data_t;

	// SSF2 bank number, 512 KB pages
	typedef logic [5:0] bank_t;

	// Light gun sensor delay in lines
	typedef logic [7:0] gun_delay_t;

	// Per-title quirks found in the header
	typedef struct packed {
		// No SRAM even though the image asks for it
		logic noram;
		// YM2612 busy flag emulation
		logic fmbusy;
		// Sega Channel, SRAM enable is not writable
		logic schan;
	} quirks_t;

endpackage

`default_nettype wire

// File: logic/cartridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module cartridge_top import cart_pkg::*; (
	input  wire         clk,
	input  wire         reset,

	// ROM download port
	input  wire         cart_dl,
	input  wire         cart_dl_wr,
	input  wire  [24:0] cart_dl_addr,
	input  bus_data_t   cart_dl_data,
	output logic        rom_wr,
	output word_addr_t  rom_wr_addr,
	output bus_data_t   rom_wr_data,

	// Mega Drive cartridge bus
	input  bus_addr_t   cart_addr,
	input  bus_data_t   cart_data_wr,
	input  wire         cart_lwr,
	input  wire         cart_oe,
	input  wire         cart_time,
	output word_addr_t  rom_addr,
	output bus_data_t   cart_data,
	output logic        cart_data_en,

	// Per-title settings
	output logic        gun_type,
	output gun_delay_t  gun_sensor_delay,
	output logic        ym2612_quirk
);

	word_addr_t       rom_sz;
	word_addr_t       rom_mask;
	quirks_t          quirks;
	bank_t      [7:0] bank;
	logic             bank_use;
	logic             sram_bank;

	assign ym2612_quirk = quirks.fmbusy;

	rom_loader u_loader (
		.clk          (clk),
		.reset        (reset),
		.cart_dl      (cart_dl),
		.cart_dl_wr   (cart_dl_wr),
		.cart_dl_addr (cart_dl_addr),
		.cart_dl_data (cart_dl_data),
		.rom_wr       (rom_wr),
		.rom_wr_addr  (rom_wr_addr),
		.rom_wr_data  (rom_wr_data),
		.rom_sz       (rom_sz),
		.rom_mask     (rom_mask)
	);

	header_detect u_detect (
		.clk              (clk),
		.cart_dl          (cart_dl),
		.cart_dl_wr       (cart_dl_wr),
		.cart_dl_addr     (cart_dl_addr),
		.cart_dl_data     (cart_dl_data),
		.quirks           (quirks),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay)
	);

	md_bank_regs u_bank_regs (
		.clk          (clk),
		.reset        (reset),
		.cart_addr    (cart_addr),
		.cart_data_wr (cart_data_wr),
		.cart_lwr     (cart_lwr),
		.cart_time    (cart_time),
		.rom_mask     (rom_mask),
		.quirks       (quirks),
		.bank         (bank),
		.bank_use     (bank_use),
		.sram_bank    (sram_bank)
	);

	md_mapper u_mapper (
		.clk          (clk),
		.reset        (reset),
		.cart_addr    (cart_addr),
		.cart_data_wr (cart_data_wr),
		.cart_lwr     (cart_lwr),
		.cart_oe      (cart_oe),
		.rom_mask     (rom_mask),
		.rom_sz       (rom_sz),
		.quirks       (quirks),
		.bank         (bank),
		.bank_use     (bank_use),
		.sram_bank    (sram_bank),
		.rom_addr     (rom_addr),
		.cart_data    (cart_data),
		.cart_data_en (cart_data_en)
	);

endmodule

`default_nettype wire

// File: logic/header_detect.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module header_detect import cart_pkg::*; (
	input  wire         clk,
	input  wire         cart_dl,
	input  wire         cart_dl_wr,
	input  wire  [24:0] cart_dl_addr,
	input  bus_data_t   cart_dl_data,
	output quirks_t     quirks,
	output logic        gun_type,
	output gun_delay_t  gun_sensor_delay
);

	logic        dl_q;
	logic        dl_word;
	logic        id_hit;
	logic [2:0]  id_word;
	logic [15:0] swapped;
	logic [87:0] cart_id;
	logic [63:0] id_key;

	assign dl_word = cart_dl & cart_dl_wr;

	// Low byte of each download word holds the earlier character
	assign swapped = {cart_dl_data[7:0], cart_dl_data[15:8]};
	assign id_hit  = cart_dl_addr[24:4] == 21'(`CART_ID_ADDR >> 4);
	assign id_word = cart_dl_addr[3:1];

	// Characters 2 to 9 carry the product code
	assign id_key = cart_id[71:8];

	// ======================================================================
	// ID capture
	// ======================================================================

	always_ff @(posedge clk) begin
		dl_q <= cart_dl;
		if (dl_word) begin
			// Word 0 opens a new image, so a stale ID never matches
			if (cart_dl_addr == `CART_SP_ADDR) begin
				cart_id <= '0;
			end
			if (id_hit) begin
				case (id_word)
					3'd0: cart_id[87:72] <= swapped;
					3'd1: cart_id[71:56] <= swapped;
					3'd2: cart_id[55:40] <= swapped;
					3'd3: cart_id[39:24] <= swapped;
					3'd4: cart_id[23:8]  <= swapped;
					3'd5: cart_id[7:0]   <= cart_dl_data[7:0];
					default: ;
				endcase
			end
		end
	end

	// ======================================================================
	// Quirk and light gun tables
	// ======================================================================

	always_ff @(posedge clk) begin
		// Only the start of a new image clears the quirks
		if (cart_dl & ~dl_q) begin
			quirks           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= `CART_GUN_DELAY_DEFAULT;
		end
		if (dl_word && cart_dl_addr == `CART_ID_DONE_ADDR) begin
			// Hellfire US
			if (id_key == "T-35036 ") quirks.fmbusy <= 1'b1;
			// Puggsy probes for RAM that is not there
			else if (id_key == "T-113016") quirks.noram <= 1'b1;
			else if (id_key == "T-68???-") quirks.schan <= 1'b1;

			if (id_key == "MK-1533 ") begin
				gun_type         <= 1'b0;
				gun_sensor_delay <= 8'd100;
			end else if (id_key == "T-95096-") begin
				// Lethal Enforcers uses the Justifier
				gun_type         <= 1'b1;
				gun_sensor_delay <= 8'd52;
			end else begin
				gun_type         <= 1'b0;
				gun_sensor_delay <= `CART_GUN_DELAY_DEFAULT;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/md_bank_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module md_bank_regs import cart_pkg::*; (
	input  wire              clk,
	input  wire              reset,
	input  bus_addr_t        cart_addr,
	input  bus_data_t        cart_data_wr,
	input  wire              cart_lwr,
	input  wire              cart_time,
	input  word_addr_t       rom_mask,
	input  quirks_t          quirks,
	output bank_t      [7:0] bank,
	output logic             bank_use,
	output logic             sram_bank
);

	logic       reg_wr;
	logic       big_image;
	logic [2:0] reg_idx;

	// Registers sit in the /TIME window, odd byte writes only
	assign reg_wr  = cart_lwr & cart_time;
	assign reg_idx = cart_addr[3:1];

	// Banking only makes sense past 4 MB
	assign big_image = |rom_mask[`CART_BANK_MASK_TOP:`CART_BANK_MASK_BOT];

	always_ff @(posedge clk) begin
		if (reset) begin
			// Identity map, page n at window n
			for (int i = 0; i < 8; i++) begin
				bank[i] <= bank_t'(i);
			end
			bank_use  <= 1'b0;
			sram_bank <= 1'b0;
		end else if (reg_wr) begin
			if (big_image) begin
				if (reg_idx != 3'd0) begin
					bank[reg_idx] <= cart_data_wr[5:0];
					bank_use      <= 1'b1;
				end else begin
					sram_bank <= cart_data_wr[0];
				end
			end else if (!quirks.schan) begin
				// Sega Channel uses this register for its own purposes
				sram_bank <= cart_data_wr[0];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/md_mapper.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module md_mapper import cart_pkg::*; (
	input  wire              clk,
	input  wire              reset,
	input  bus_addr_t        cart_addr,
	input  bus_data_t        cart_data_wr,
	input  wire              cart_lwr,
	input  wire              cart_oe,
	input  word_addr_t       rom_mask,
	input  word_addr_t       rom_sz,
	input  quirks_t          quirks,
	input  bank_t      [7:0] bank,
	input  wire              bank_use,
	input  wire              sram_bank,
	output word_addr_t       rom_addr,
	output bus_data_t        cart_data,
	output logic             cart_data_en
);

	logic                       sram_cs;
	logic [`CART_SRAM_AW-1:0]   sram_addr;
	logic [7:0]                 sram [0:(2**`CART_SRAM_AW)-1];
	word_addr_t                 flat_addr;

	// ======================================================================
	// ROM address translation
	// ======================================================================

	assign flat_addr = bank_use ? {bank[cart_addr[21:19]], cart_addr[18:1]}
	                            : {1'b0, cart_addr};
	assign rom_addr  = flat_addr & rom_mask;

	// ======================================================================
	// Battery SRAM
	// ======================================================================

	// 0x200000 window, either enabled by register or past the ROM end
	assign sram_cs = (cart_addr[23:21] == 3'd1) &&
	                 (sram_bank || ({1'b0, cart_addr} >= rom_sz && ~&cart_addr[20:19])) &&
	                 !quirks.noram;

	assign sram_addr = cart_addr[`CART_SRAM_AW:1];

	always_ff @(posedge clk) begin
		if (sram_cs && cart_lwr) begin
			sram[sram_addr] <= cart_data_wr[7:0];
		end
		// Byte wide part, same byte on both lanes
		if (sram_cs && cart_oe) begin
			cart_data <= {sram[sram_addr], sram[sram_addr]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cart_data_en <= 1'b0;
		end else begin
			cart_data_en <= sram_cs & cart_oe;
		end
	end

	// Read data only ever answers a sampled read strobe
	data_en_needs_oe: assert property (
		@(posedge clk) disable iff (reset)
		!cart_oe |=> !cart_data_en
	);

endmodule

`default_nettype wire

// File: logic/rom_loader.sv
`timescale 1ns/100ps
`default_nettype none

module rom_loader import cart_pkg::*; (
	input  wire         clk,
	input  wire         reset,
	input  wire         cart_dl,
	input  wire         cart_dl_wr,
	input  wire  [24:0] cart_dl_addr,
	input  bus_data_t   cart_dl_data,
	output logic        rom_wr,
	output word_addr_t  rom_wr_addr,
	output bus_data_t   rom_wr_data,
	output word_addr_t  rom_sz,
	output word_addr_t  rom_mask
);

	logic       dl_q;
	logic       dl_start;
	logic       dl_word;
	word_addr_t dl_index;

	assign dl_start = cart_dl & ~dl_q;
	assign dl_word  = cart_dl & cart_dl_wr;
	assign dl_index = cart_dl_addr[24:1];

	// One write strobe per download word
	always_ff @(posedge clk) begin
		dl_q <= cart_dl;
		if (reset) begin
			rom_wr <= 1'b0;
		end else begin
			rom_wr <= dl_word;
		end
	end

	always_ff @(posedge clk) begin
		if (dl_word) begin
			rom_wr_addr <= dl_index;
			rom_wr_data <= cart_dl_data;
		end
	end

	// Size and mask follow the highest words seen in this download
	always_ff @(posedge clk) begin
		if (dl_start) begin
			rom_sz   <= '0;
			rom_mask <= '0;
		end
		if (dl_word) begin
			rom_sz   <= dl_index + 1'b1;
			rom_mask <= (dl_start ? '0 : rom_mask) | dl_index;
		end
	end

	// A ROM write only ever comes from a download word
	rom_wr_in_download: assert property (
		@(posedge clk) disable iff (reset)
		$rose(rom_wr) |-> $past(cart_dl)
	);

endmodule

`default_nettype wire

// File: testbench/cartridge_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cart_defs.svh"

module cartridge_tb import cart_pkg::*; ();

	typedef enum logic [1:0] {k_download, k_write, k_read, k_gun} kind_t;

	// One stimulus step with its expected gun outputs
	typedef struct {
		kind_t       kind;
		logic [24:0] addr;
		bus_data_t   data;
		logic        rnd;
		logic        tim;
		logic [9:0]  expv;
	} entry_t;

	logic        clk;
	logic        reset;
	logic        cart_dl;
	logic        cart_dl_wr;
	logic [24:0] cart_dl_addr;
	bus_data_t   cart_dl_data;
	logic        rom_wr;
	word_addr_t  rom_wr_addr;
	bus_data_t   rom_wr_data;
	bus_addr_t   cart_addr;
	bus_data_t   cart_data_wr;
	logic        cart_lwr;
	logic        cart_oe;
	logic        cart_time;
	word_addr_t  rom_addr;
	bus_data_t   cart_data;
	logic        cart_data_en;
	logic        gun_type;
	gun_delay_t  gun_sensor_delay;
	logic        ym2612_quirk;

	entry_t      tbl [$];
	logic        table_ready;
	int          errors;

	// Reference state of the cartridge
	word_addr_t  mask_m;
	word_addr_t  size_m;
	bank_t       bank_m [8];
	logic        bank_use_m;
	logic        sram_bank_m;
	logic        noram_m;
	logic [7:0]  sram_m [int];

	cartridge_top u_dut (
		.clk              (clk),
		.reset            (reset),
		.cart_dl          (cart_dl),
		.cart_dl_wr       (cart_dl_wr),
		.cart_dl_addr     (cart_dl_addr),
		.cart_dl_data     (cart_dl_data),
		.rom_wr           (rom_wr),
		.rom_wr_addr      (rom_wr_addr),
		.rom_wr_data      (rom_wr_data),
		.cart_addr        (cart_addr),
		.cart_data_wr     (cart_data_wr),
		.cart_lwr         (cart_lwr),
		.cart_oe          (cart_oe),
		.cart_time        (cart_time),
		.rom_addr         (rom_addr),
		.cart_data        (cart_data),
		.cart_data_en     (cart_data_en),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay),
		.ym2612_quirk     (ym2612_quirk)
	);

	always #5 clk = ~clk;

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic report_mismatch(input string msg);
		errors++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [63:0] product_code(input int sel);
		case (sel)
			0: return "MK-1533 ";
			1: return "T-35036 ";
			2: return "T-113016";
			3: return "T-95096-";
			default: return "00001009";
		endcase
	endfunction

	function automatic logic sram_select(input bus_addr_t a);
		logic past_rom;
		past_rom = ({1'b0, a} >= size_m) && !(a[20] && a[19]);
		return (a[23:21] == 3'd1) && (sram_bank_m || past_rom) && !noram_m;
	endfunction

	// Strobe must follow each download word by exactly one cycle
	task automatic load_word(input logic [24:0] byte_addr, input bus_data_t data);
		word_addr_t idx;
		idx = byte_addr[24:1];
		cart_dl_wr = 1'b1;
		cart_dl_addr = byte_addr;
		cart_dl_data = data;
		next_cycle();
		cart_dl_wr = 1'b0;
		if (rom_wr !== 1'b1 || rom_wr_addr !== idx || rom_wr_data !== data)
			report_mismatch($sformatf("rom_wr %b addr %h data %h, expected 1 %h %h",
				rom_wr, rom_wr_addr, rom_wr_data, idx, data));
		mask_m = mask_m | idx;
		size_m = idx + 24'd1;
		next_cycle();
		if (rom_wr !== 1'b0)
			report_mismatch("rom_wr held for more than one cycle");
	endtask

	// SP word, header ID, finalize word, then an optional far word
	task automatic run_download(input logic [24:0] extra, input int sel);
		logic [87:0] id;
		logic [7:0]  chars [12];
		id = {"GM", product_code(sel), " "};
		for (int k = 0; k < 11; k++)
			chars[k] = id[87 - 8*k -: 8];
		chars[11] = 8'h20;
		mask_m = '0;
		noram_m = (product_code(sel) == "T-113016");
		cart_dl = 1'b1;
		next_cycle();
		load_word(`CART_SP_ADDR, 16'h00ff);
		// Low byte of each header word holds the earlier character
		for (int w = 0; w < 6; w++)
			load_word(`CART_ID_ADDR + 25'(2*w), {chars[2*w+1], chars[2*w]});
		load_word(`CART_ID_DONE_ADDR, 16'h2020);
		if (extra != 25'd0)
			load_word(extra, 16'ha5a5);
		cart_dl = 1'b0;
		next_cycle();
	endtask

	task automatic bus_write(input logic [23:0] byte_addr, input bus_data_t data, input logic tim);
		bus_addr_t a;
		logic      sel;
		a = byte_addr[23:1];
		sel = sram_select(a);
		cart_addr = a;
		cart_data_wr = data;
		cart_lwr = 1'b1;
		cart_time = tim;
		if (sel)
			sram_m[a[15:1]] = data[7:0];
		if (tim && |mask_m[`CART_BANK_MASK_TOP:`CART_BANK_MASK_BOT]) begin
			if (a[3:1] != 3'd0) begin
				bank_m[a[3:1]] = data[5:0];
				bank_use_m = 1'b1;
			end else begin
				sram_bank_m = data[0];
			end
		end else if (tim) begin
			sram_bank_m = data[0];
		end
		next_cycle();
		cart_lwr = 1'b0;
		cart_time = 1'b0;
	endtask

	task automatic bus_read(input logic [23:0] byte_addr);
		bus_addr_t  a;
		word_addr_t exp_rom;
		logic       sel;
		logic [7:0] b;
		a = byte_addr[23:1];
		exp_rom = bank_use_m ? {bank_m[a[21:19]], a[18:1]} : {1'b0, a};
		exp_rom = exp_rom & mask_m;
		sel = sram_select(a);
		cart_addr = a;
		cart_oe = 1'b1;
		#4;
		if (rom_addr !== exp_rom)
			report_mismatch($sformatf("rom_addr %h for bus %h, expected %h",
				rom_addr, byte_addr, exp_rom));
		next_cycle();
		cart_oe = 1'b0;
		if (cart_data_en !== sel) begin
			report_mismatch($sformatf("cart_data_en %b at %h, expected %b",
				cart_data_en, byte_addr, sel));
		end else if (sel && sram_m.exists(a[15:1])) begin
			b = sram_m[a[15:1]];
			if (cart_data !== {b, b})
				report_mismatch($sformatf("cart_data %h at %h, expected %h",
					cart_data, byte_addr, {b, b}));
		end
	endtask

	// Packed as FM busy, gun type, sensor delay
	task automatic check_gun(input logic [9:0] expv);
		if (ym2612_quirk !== expv[9] || gun_type !== expv[8] || gun_sensor_delay !== expv[7:0])
			report_mismatch($sformatf("fm %b gun %b delay %0d, expected %b %b %0d",
				ym2612_quirk, gun_type, gun_sensor_delay, expv[9], expv[8], expv[7:0]));
		next_cycle();
	endtask

	task automatic add_entry(input kind_t k, input logic [24:0] addr, input bus_data_t data,
			input logic rnd, input logic tim, input logic [9:0] expv);
		entry_t e;
		e.kind = k;
		e.addr = addr;
		e.data = data;
		e.rnd = rnd;
		e.tim = tim;
		e.expv = expv;
		tbl.push_back(e);
	endtask

	// ========================================================================
	// Stimulus table
	// ========================================================================

	task automatic build_table();
		// Small image with the light gun title
		add_entry(k_download, 25'h000400, 16'd0, 1'b0, 1'b0, 10'd0);
		add_entry(k_gun, 25'd0, 16'd0, 1'b0, 1'b0, {1'b0, 1'b0, 8'd100});
		add_entry(k_read, 25'h0012a6, 16'd0, 1'b0, 1'b0, 10'd0);
		add_entry(k_read, 25'h3ffffe, 16'd0, 1'b0, 1'b0, 10'd0);
		add_entry(k_write, 25'ha130f0, 16'h0001, 1'b0, 1'b1, 10'd0);
		add_entry(k_write, 25'h200010, 16'd0, 1'b1, 1'b0, 10'd0);
		add_entry(k_read, 25'h200010, 16'd0, 1'b0, 1'b0, 10'd0);
		add_entry(k_write, 25'h20abcc, 16'd0, 1'b1, 1'b0, 10'd0);
		add_entry(k_read, 25'h20abcc, 16'd0, 1'b0, 1'b0, 10'd0);
		// FM busy title
		add_entry(k_download, 25'd0, 16'd1, 1'b0, 1'b0, 10'd0);
		add_entry(k_gun, 25'd0, 16'd0, 1'b0, 1'b0, {1'b1, 1'b0, `CART_GUN_DELAY_DEFAULT});
		add_entry(k_read, 25'h000156, 16'd0, 1'b0, 1'b0, 10'd0);
		// No SRAM title
		add_entry(k_download, 25'd0, 16'd2, 1'b0, 1'b0, 10'd0);
		add_entry(k_gun, 25'd0, 16'd0, 1'b0, 1'b0, {1'b0, 1'b0, `CART_GUN_DELAY_DEFAULT});
		add_entry(k_read, 25'h200010, 16'd0, 1'b0, 1'b0, 10'd0);
		// Large image with SSF2 banking
		add_entry(k_download, 25'h7ffffe, 16'd4, 1'b0, 1'b0, 10'd0);
		add_entry(k_gun, 25'd0, 16'd0, 1'b0, 1'b0, {1'b0, 1'b0, `CART_GUN_DELAY_DEFAULT});
		add_entry(k_write, 25'ha130f6, 16'd0, 1'b1, 1'b1, 10'd0);
		add_entry(k_write, 25'ha130fe, 16'd0, 1'b1, 1'b1, 10'd0);
		add_entry(k_read, 25'h1a2468, 16'd0, 1'b0, 1'b0, 10'd0);
		add_entry(k_read, 25'h3c0002, 16'd0, 1'b0, 1'b0, 10'd0);
		add_entry(k_read, 25'h080000, 16'd0, 1'b0, 1'b0, 10'd0);
		add_entry(k_write, 25'ha130f0, 16'h0000, 1'b0, 1'b1, 10'd0);
		add_entry(k_read, 25'h200010, 16'd0, 1'b0, 1'b0, 10'd0);
		add_entry(k_write, 25'ha130f0, 16'h0001, 1'b0, 1'b1, 10'd0);
		add_entry(k_read, 25'h200010, 16'd0, 1'b0, 1'b0, 10'd0);
		// Justifier title
		add_entry(k_download, 25'd0, 16'd3, 1'b0, 1'b0, 10'd0);
		add_entry(k_gun, 25'd0, 16'd0, 1'b0, 1'b0, {1'b0, 1'b1, 8'd52});
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		void'($urandom(32'hf7c3));
		table_ready = 1'b0;
		clk = 1'b0;
		reset = 1'b1;
		cart_dl = 1'b0;
		cart_dl_wr = 1'b0;
		cart_dl_addr = '0;
		cart_dl_data = '0;
		cart_addr = '0;
		cart_data_wr = '0;
		cart_lwr = 1'b0;
		cart_oe = 1'b0;
		cart_time = 1'b0;
		errors = 0;
		mask_m = '0;
		size_m = '0;
		bank_use_m = 1'b0;
		sram_bank_m = 1'b0;
		noram_m = 1'b0;
		for (int n = 0; n < 8; n++)
			bank_m[n] = bank_t'(n);
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (tbl[i]) begin
			case (tbl[i].kind)
				k_download: run_download(tbl[i].addr, int'(tbl[i].data));
				k_write: bus_write(tbl[i].addr[23:0],
					tbl[i].rnd ? bus_data_t'($urandom) : tbl[i].data, tbl[i].tim);
				k_read: bus_read(tbl[i].addr[23:0]);
				default: check_gun(tbl[i].expv);
			endcase
		end
		$display("Finished %0d table entries with %0d errors", tbl.size(), errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the table length plus reset
	initial begin
		wait (table_ready === 1'b1);
		repeat (tbl.size() * 20 + 8) @(posedge clk);
		$display("Watchdog expired before the stimulus table was finished");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
